// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= mouse_axis_tb
FILELIST  ?= mouse_axis.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo ">>> FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: mouse_axis.f
src/mouse_pkg.sv
src/joy_pkg.sv
src/mouse_packet_decode.sv
src/delta_limiter.sv
src/axis_accumulator.sv
src/port_router.sv
src/mouse_axis_top.sv
sim/mouse_axis_properties.sv
sim/mouse_axis_tb.sv

// File: sim/mouse_axis_properties.sv
// Assertions hold only outside reset; positions are checked on every clock edge after reset
module mouse_axis_properties (
	input logic              clk_sys,
	input logic              areset,
	input logic              strobe_i,
	input logic              pkt_valid_i,
	input mouse_pkg::delta_t pos_x_i,
	input mouse_pkg::delta_t pos_y_i,
	input logic              cpu_halt_i,
	input logic              mouse_active_i
);

	timeunit 1ns;
	timeprecision 100ps;

	// ====================
	// Decode pulse
	// ====================

	// A steady strobe ends any report pulse
	pulse_needs_change: assert property (@(posedge clk_sys) disable iff (areset)
		pkt_valid_i && $stable(strobe_i) |=> !pkt_valid_i)
		else $error("pkt_valid stayed high while the strobe did not change");

	// ====================
	// Position and mode
	// ====================

	x_in_range: assert property (@(posedge clk_sys) disable iff (areset)
		pos_x_i >= mouse_pkg::axis_min && pos_x_i <= mouse_pkg::axis_max)
		else $error("pos_x left the axis range");

	y_in_range: assert property (@(posedge clk_sys) disable iff (areset)
		pos_y_i >= mouse_pkg::axis_min && pos_y_i <= mouse_pkg::axis_max)
		else $error("pos_y left the axis range");

	halt_ends_emulation: assert property (@(posedge clk_sys) disable iff (areset)
		cpu_halt_i |=> !mouse_active_i)
		else $error("mouse emulation stayed on after a CPU halt");

endmodule

// File: sim/mouse_axis_tb.sv
// Runs from the project root to find its data file; records with extra reports keep them even
module mouse_axis_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_cycles = 8;
	localparam int n_outputs = 7;

	typedef struct packed {
		int               test;
		logic [24:0]      pkt;
		logic [15:0]      joy0;
		logic [15:0]      joy1;
		logic [15:0]      joya0;
		logic [15:0]      joya1;
		logic             halt;
		logic             swap;
		logic             inv;
		int               extra;
		int               hold;
		int               idle;
		logic [6:0][15:0] expected;
	} record_t;

	logic        clk_sys;
	logic        areset;
	logic [24:0] ps2_mouse_i;
	logic [15:0] joy0_i;
	logic [15:0] joy1_i;
	logic [15:0] joya0_i;
	logic [15:0] joya1_i;
	logic        cpu_halt_i;
	logic        swap_joy_i;
	logic        invert_y_i;
	logic [13:0] joy1_o;
	logic [13:0] joy2_o;
	logic [7:0]  joy1_x_o;
	logic [7:0]  joy1_y_o;
	logic [7:0]  joy2_x_o;
	logic [7:0]  joy2_y_o;
	logic        mouse_active_o;

	record_t records[$];
	logic    limit_ready;
	int      cycle_limit;
	int      errors;
	int      checks;
	int      tests_done;
	int      cur_test;
	int      test_errors;
	string   out_names[n_outputs] = '{"joy1_o", "joy2_o", "joy1_x_o", "joy1_y_o",
		"joy2_x_o", "joy2_y_o", "mouse_active_o"};

	mouse_axis_top i_mouse_axis_top (.*);

	bind mouse_axis_top mouse_axis_properties i_mouse_axis_properties (
		.clk_sys        (clk_sys),
		.areset         (areset),
		.strobe_i       (ps2_mouse_i[mouse_pkg::strobe_bit]),
		.pkt_valid_i    (pkt_valid),
		.pos_x_i        (pos_x),
		.pos_y_i        (pos_y),
		.cpu_halt_i     (cpu_halt_i),
		.mouse_active_i (mouse_active_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Watchdog sized from the loaded records
	initial begin
		int cycles;
		cycles = 0;
		wait (limit_ready);
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
		$display(">>> FAIL");
		$finish;
	end

	// ====================
	// Record handling
	// ====================

	task automatic load_records();
		int          fd;
		int          n;
		string       line;
		logic [31:0] fld [18];
		record_t     rec;
		fd = $fopen("sim/mouse_axis_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open sim/mouse_axis_testdata.txt");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %d %d %h %h %h %h %h %h %h",
				fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
				fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16], fld[17]);
			if (n != 18) begin
				$display("Malformed line in the test data: %s", line);
				errors++;
				continue;
			end
			rec.test  = fld[0];
			rec.pkt   = fld[1][24:0];
			rec.joy0  = fld[2][15:0];
			rec.joy1  = fld[3][15:0];
			rec.joya0 = fld[4][15:0];
			rec.joya1 = fld[5][15:0];
			rec.halt  = fld[6][0];
			rec.swap  = fld[7][0];
			rec.inv   = fld[8][0];
			rec.extra = fld[9];
			rec.hold  = fld[10];
			rec.idle  = $urandom_range(3, 0);
			for (int i = 0; i < n_outputs; i++)
				rec.expected[i] = fld[11 + i][15:0];
			records.push_back(rec);
		end
		$fclose(fd);
	endtask

	task automatic apply_record(input record_t r);
		ps2_mouse_i <= r.pkt;
		joy0_i      <= r.joy0;
		joy1_i      <= r.joy1;
		joya0_i     <= r.joya0;
		joya1_i     <= r.joya1;
		cpu_halt_i  <= r.halt;
		swap_joy_i  <= r.swap;
		invert_y_i  <= r.inv;
		// Burst of reports, one strobe toggle per cycle
		for (int k = 1; k <= r.extra; k++) begin
			@(posedge clk_sys);
			ps2_mouse_i <= {r.pkt[24] ^ k[0], r.pkt[23:0]};
		end
	endtask

	task automatic check_outputs(input record_t r);
		logic [6:0][15:0] actual;
		actual[0] = {2'b00, joy1_o};
		actual[1] = {2'b00, joy2_o};
		actual[2] = {8'h00, joy1_x_o};
		actual[3] = {8'h00, joy1_y_o};
		actual[4] = {8'h00, joy2_x_o};
		actual[5] = {8'h00, joy2_y_o};
		actual[6] = {15'd0, mouse_active_o};
		for (int i = 0; i < n_outputs; i++) begin
			checks++;
			if (actual[i] !== r.expected[i]) begin
				$display("MISMATCH at %0d ns: %s expected %h got %h",
					$time, out_names[i], r.expected[i], actual[i]);
				errors++;
				test_errors++;
			end
		end
	endtask

	task automatic close_test();
		if (cur_test >= 0) begin
			$display("Test %0d done with %0d mismatches", cur_test, test_errors);
			tests_done++;
		end
		test_errors = 0;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int total;
		void'($urandom(63));
		errors = 0;
		checks = 0;
		tests_done = 0;
		cur_test = -1;
		test_errors = 0;
		limit_ready = 1'b0;
		areset = 1'b1;
		ps2_mouse_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		joya0_i = '0;
		joya1_i = '0;
		cpu_halt_i = 1'b0;
		swap_joy_i = 1'b0;
		invert_y_i = 1'b0;
		load_records();
		if (records.size() == 0) begin
			$display("No test records were loaded");
			errors++;
		end
		total = reset_cycles;
		foreach (records[i])
			total += 2 + records[i].extra + records[i].hold + records[i].idle;
		cycle_limit = 2 * total;
		limit_ready = 1'b1;

		repeat (reset_cycles) @(posedge clk_sys);
		areset <= 1'b0;

		foreach (records[i]) begin
			if (records[i].test != cur_test) begin
				close_test();
				cur_test = records[i].test;
			end
			@(posedge clk_sys);
			apply_record(records[i]);
			repeat (records[i].hold) @(posedge clk_sys);
			// Mid-cycle sample, well clear of the register updates
			@(negedge clk_sys);
			check_outputs(records[i]);
			repeat (records[i].idle) @(posedge clk_sys);
		end
		close_test();

		$display("Tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: sim/mouse_axis_testdata.txt
# test pkt joy0 joy1 joya0 joya1 halt swap inv extra hold, then expected joy1_o joy2_o
# joy1_x joy1_y joy2_x joy2_y active; test, extra and hold decimal, all others hex
# 1 single report, then the second button
1 1F80621 0003 0010 0000 2211 0 0 0 0 4 0083 0010 03 FC 11 22 1
1 0000002 0003 0010 0000 2211 0 0 0 0 4 0103 0010 03 FC 11 22 1
# 2 step limit, saturation high, clear, saturation low
2 1007802 0003 0010 0000 2211 0 0 0 0 4 0103 0010 0D FC 11 22 1
2 0880022 0003 0010 0000 2211 0 0 0 0 4 0103 0010 0D F2 11 22 1
2 1007802 0003 0010 0000 2211 0 0 0 14 4 0103 0010 7F F2 11 22 1
2 1007802 0003 0010 0000 2211 1 0 0 0 2 0003 0010 00 00 11 22 0
2 0008812 0003 0010 0000 2211 0 0 0 14 4 0103 0010 80 00 11 22 1
# 3 inverted Y
3 10A0002 0003 0010 0000 2211 0 0 1 0 4 0103 0010 80 FB 11 22 1
3 0FA0022 0003 0010 0000 2211 0 0 1 0 4 0103 0010 80 FE 11 22 1
# 4 real stick and CPU halt end emulation, clear wins over a report
4 0FA0022 0083 0010 4050 2211 0 0 0 0 2 0083 0010 50 40 11 22 0
4 0FA0022 0083 0010 0000 2211 0 0 0 0 2 0083 0010 00 00 11 22 0
4 1000603 0083 0010 0000 2211 0 0 0 0 4 0183 0010 03 00 11 22 1
4 1000603 0083 0010 0000 2211 1 0 0 0 2 0083 0010 00 00 11 22 0
4 0000603 0083 0010 0000 2211 1 0 0 0 4 0083 0010 00 00 11 22 0
# 5 swapped ports
5 1FC0A22 0083 0010 0000 2211 0 1 0 0 4 0010 0103 11 22 05 FE 1
5 1FC0A22 0083 C123 0000 8877 0 1 0 0 2 0123 0103 77 88 05 FE 1
5 1FC0A22 0083 C123 0000 8877 0 0 0 0 2 0103 0123 05 FE 77 88 1

// File: src/axis_accumulator.sv
// Position saturates at axis_min..axis_max; a real stick or a halted CPU ends emulation at once
module axis_accumulator (
	input  logic                           clk_sys,
	input  logic                           areset,
	input  logic                           lim_valid_i,
	input  mouse_pkg::delta_t              lim_dx_i,
	input  mouse_pkg::delta_t              lim_dy_i,
	input  logic [joy_pkg::joy_raw_w-1:0]  joya0_i,
	input  logic                           cpu_halt_i,
	output mouse_pkg::delta_t              pos_x_o,
	output mouse_pkg::delta_t              pos_y_o,
	output logic                           emu_active_o
);

	mouse_pkg::delta_t sum_x;
	mouse_pkg::delta_t sum_y;
	mouse_pkg::delta_t next_x;
	mouse_pkg::delta_t next_y;
	logic              clear;

	// Any analog activity on the real stick hands control back to it
	assign clear = (joya0_i != '0) || cpu_halt_i;

	// ====================
	// Add and saturate
	// ====================

	// Step is at most 10, so the sum never wraps in nine bits
	assign sum_x = pos_x_o + lim_dx_i;
	assign sum_y = pos_y_o + lim_dy_i;

	always_comb begin
		if (sum_x > mouse_pkg::axis_max)
			next_x = mouse_pkg::axis_max;
		else if (sum_x < mouse_pkg::axis_min)
			next_x = mouse_pkg::axis_min;
		else
			next_x = sum_x;

		if (sum_y > mouse_pkg::axis_max)
			next_y = mouse_pkg::axis_max;
		else if (sum_y < mouse_pkg::axis_min)
			next_y = mouse_pkg::axis_min;
		else
			next_y = sum_y;
	end

	// ====================
	// Position state
	// ====================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			pos_x_o      <= '0;
			pos_y_o      <= '0;
			emu_active_o <= 1'b0;
		end else if (clear) begin
			// Clear beats a report in the same cycle
			pos_x_o      <= '0;
			pos_y_o      <= '0;
			emu_active_o <= 1'b0;
		end else if (lim_valid_i) begin
			pos_x_o      <= next_x;
			pos_y_o      <= next_y;
			emu_active_o <= 1'b1;
		end
	end

endmodule

// File: src/delta_limiter.sv
// Steps are clipped to plus or minus delta_limit; invert_y_i is read when the report passes
module delta_limiter (
	input  logic              clk_sys,
	input  logic              areset,
	input  logic              invert_y_i,
	input  logic              pkt_valid_i,
	input  mouse_pkg::delta_t dx_i,
	input  mouse_pkg::delta_t dy_i,
	output logic              lim_valid_o,
	output mouse_pkg::delta_t lim_dx_o,
	output mouse_pkg::delta_t lim_dy_o
);

	mouse_pkg::delta_t clip_dx;
	mouse_pkg::delta_t clip_dy;

	// Clip both axes to the allowed step
	always_comb begin
		clip_dx = dx_i;
		if (dx_i > mouse_pkg::delta_limit)
			clip_dx = mouse_pkg::delta_limit;
		else if (dx_i < -mouse_pkg::delta_limit)
			clip_dx = -mouse_pkg::delta_limit;

		clip_dy = dy_i;
		if (dy_i > mouse_pkg::delta_limit)
			clip_dy = mouse_pkg::delta_limit;
		else if (dy_i < -mouse_pkg::delta_limit)
			clip_dy = -mouse_pkg::delta_limit;
	end

	always_ff @(posedge clk_sys) begin
		if (areset)
			lim_valid_o <= 1'b0;
		else
			lim_valid_o <= pkt_valid_i;
	end

	// Inverted Y moves the other way, same as subtracting the step
	always_ff @(posedge clk_sys) begin
		if (pkt_valid_i) begin
			lim_dx_o <= clip_dx;
			lim_dy_o <= invert_y_i ? -clip_dy : clip_dy;
		end
	end

endmodule

// File: src/joy_pkg.sv
// Joystick words follow the host bridge layout; only the low 14 digital bits reach the ports
package joy_pkg;

	// ====================
	// Word widths
	// ====================

	// Digital word as kept per port
	localparam int joy_digital_w = 14;

	// Digital and analog words as delivered by the host
	localparam int joy_raw_w = 16;

	// One analog axis byte, X in the low byte and Y in the high byte of the raw word
	typedef logic [7:0] axis_t;

	// ====================
	// Button positions
	// ====================

	// Fire 2 sits here and fire 3 right above it
	localparam int fire2_bit = 7;

endpackage

// File: src/mouse_axis_top.sv
// Four-cycle path from a strobe change to the port outputs; no back-pressure anywhere
module mouse_axis_top (
	input  logic                              clk_sys,
	input  logic                              areset,
	input  logic [mouse_pkg::mouse_pkt_w-1:0] ps2_mouse_i,
	input  logic [joy_pkg::joy_raw_w-1:0]     joy0_i,
	input  logic [joy_pkg::joy_raw_w-1:0]     joy1_i,
	input  logic [joy_pkg::joy_raw_w-1:0]     joya0_i,
	input  logic [joy_pkg::joy_raw_w-1:0]     joya1_i,
	input  logic                              cpu_halt_i,
	input  logic                              swap_joy_i,
	input  logic                              invert_y_i,
	output logic [joy_pkg::joy_digital_w-1:0] joy1_o,
	output logic [joy_pkg::joy_digital_w-1:0] joy2_o,
	output joy_pkg::axis_t                    joy1_x_o,
	output joy_pkg::axis_t                    joy1_y_o,
	output joy_pkg::axis_t                    joy2_x_o,
	output joy_pkg::axis_t                    joy2_y_o,
	output logic                              mouse_active_o
);

	logic              pkt_valid;
	mouse_pkg::delta_t dx;
	mouse_pkg::delta_t dy;
	logic [1:0]        btn;
	logic              lim_valid;
	mouse_pkg::delta_t lim_dx;
	mouse_pkg::delta_t lim_dy;
	mouse_pkg::delta_t pos_x;
	mouse_pkg::delta_t pos_y;
	logic              emu_active;

	assign mouse_active_o = emu_active;

	mouse_packet_decode i_mouse_packet_decode (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.ps2_mouse_i (ps2_mouse_i),
		.pkt_valid_o (pkt_valid),
		.dx_o        (dx),
		.dy_o        (dy),
		.btn_o       (btn)
	);

	delta_limiter i_delta_limiter (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.invert_y_i  (invert_y_i),
		.pkt_valid_i (pkt_valid),
		.dx_i        (dx),
		.dy_i        (dy),
		.lim_valid_o (lim_valid),
		.lim_dx_o    (lim_dx),
		.lim_dy_o    (lim_dy)
	);

	axis_accumulator i_axis_accumulator (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.lim_valid_i  (lim_valid),
		.lim_dx_i     (lim_dx),
		.lim_dy_i     (lim_dy),
		.joya0_i      (joya0_i),
		.cpu_halt_i   (cpu_halt_i),
		.pos_x_o      (pos_x),
		.pos_y_o      (pos_y),
		.emu_active_o (emu_active)
	);

	// Buttons bypass the limiter and accumulator
	port_router i_port_router (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.swap_joy_i   (swap_joy_i),
		.emu_active_i (emu_active),
		.pos_x_i      (pos_x),
		.pos_y_i      (pos_y),
		.btn_i        (btn),
		.joy0_i       (joy0_i),
		.joy1_i       (joy1_i),
		.joya0_i      (joya0_i),
		.joya1_i      (joya1_i),
		.joy1_o       (joy1_o),
		.joy2_o       (joy2_o),
		.joy1_x_o     (joy1_x_o),
		.joy1_y_o     (joy1_y_o),
		.joy2_x_o     (joy2_x_o),
		.joy2_y_o     (joy2_y_o)
	);

endmodule

// File: src/mouse_packet_decode.sv
// A report is any change of the strobe bit; a strobe level present at reset release gives no report
module mouse_packet_decode (
	input  logic                                 clk_sys,
	input  logic                                 areset,
	input  logic [mouse_pkg::mouse_pkt_w-1:0]    ps2_mouse_i,
	output logic                                 pkt_valid_o,
	output mouse_pkg::delta_t                    dx_o,
	output mouse_pkg::delta_t                    dy_o,
	output logic [1:0]                           btn_o
);

	logic stb_q;
	logic stb_change;

	assign stb_change = ps2_mouse_i[mouse_pkg::strobe_bit] != stb_q;

	// Strobe history and report pulse
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			// Follow the strobe so that leaving reset looks like no change
			stb_q       <= ps2_mouse_i[mouse_pkg::strobe_bit];
			pkt_valid_o <= 1'b0;
		end else begin
			stb_q       <= ps2_mouse_i[mouse_pkg::strobe_bit];
			pkt_valid_o <= stb_change;
		end
	end

	// Buttons are held between reports and read at all times downstream
	always_ff @(posedge clk_sys) begin
		if (areset) begin
			btn_o <= 2'b00;
		end else if (stb_change) begin
			btn_o <= ps2_mouse_i[mouse_pkg::btn_hi:mouse_pkg::btn_lo];
		end
	end

	// Deltas: sign bit doubled on top of the 7-bit magnitude
	always_ff @(posedge clk_sys) begin
		if (stb_change) begin
			dx_o <= {ps2_mouse_i[mouse_pkg::x_sign_bit],
				ps2_mouse_i[mouse_pkg::x_sign_bit],
				ps2_mouse_i[mouse_pkg::x_mag_hi:mouse_pkg::x_mag_lo]};
			dy_o <= {ps2_mouse_i[mouse_pkg::y_sign_bit],
				ps2_mouse_i[mouse_pkg::y_sign_bit],
				ps2_mouse_i[mouse_pkg::y_mag_hi:mouse_pkg::y_mag_lo]};
		end
	end

endmodule

// File: src/mouse_pkg.sv
// Assumes the 25-bit PS/2 mouse word of the host bridge, with a toggling strobe in bit 24
package mouse_pkg;

	// ====================
	// Packet word layout
	// ====================

	localparam int mouse_pkt_w = 25;

	// Toggles once per new movement report
	localparam int strobe_bit = 24;

	// Sign bits sit in the first packet byte
	localparam int x_sign_bit = 4;
	localparam int y_sign_bit = 5;

	// Movement magnitudes, 7 bits each
	localparam int x_mag_hi = 15;
	localparam int x_mag_lo = 9;
	localparam int y_mag_hi = 23;
	localparam int y_mag_lo = 17;

	// Left and right buttons
	localparam int btn_lo = 0;
	localparam int btn_hi = 1;

	// ====================
	// Delta and position
	// ====================

	// Nine bits hold a full sign-extended delta and a position plus one step
	typedef logic signed [8:0] delta_t;

	// Largest move accepted from one report
	localparam delta_t delta_limit = 9'sd10;

	// Emulated stick range, one signed byte
	localparam delta_t axis_max = 9'sd127;
	localparam delta_t axis_min = -9'sd128;

endpackage

// File: src/port_router.sv
// Only player 0 can be mouse driven; joystick inputs are sampled and appear one cycle later
module port_router (
	input  logic                           clk_sys,
	input  logic                           areset,
	input  logic                           swap_joy_i,
	input  logic                           emu_active_i,
	input  mouse_pkg::delta_t              pos_x_i,
	input  mouse_pkg::delta_t              pos_y_i,
	input  logic [1:0]                     btn_i,
	input  logic [joy_pkg::joy_raw_w-1:0]  joy0_i,
	input  logic [joy_pkg::joy_raw_w-1:0]  joy1_i,
	input  logic [joy_pkg::joy_raw_w-1:0]  joya0_i,
	input  logic [joy_pkg::joy_raw_w-1:0]  joya1_i,
	output logic [joy_pkg::joy_digital_w-1:0] joy1_o,
	output logic [joy_pkg::joy_digital_w-1:0] joy2_o,
	output joy_pkg::axis_t                 joy1_x_o,
	output joy_pkg::axis_t                 joy1_y_o,
	output joy_pkg::axis_t                 joy2_x_o,
	output joy_pkg::axis_t                 joy2_y_o
);

	logic [joy_pkg::joy_digital_w-1:0] p0_dig;
	logic [joy_pkg::joy_digital_w-1:0] p1_dig;
	joy_pkg::axis_t                    p0_x;
	joy_pkg::axis_t                    p0_y;
	joy_pkg::axis_t                    p1_x;
	joy_pkg::axis_t                    p1_y;

	// ====================
	// Player values
	// ====================

	always_comb begin
		p0_dig = joy0_i[joy_pkg::joy_digital_w-1:0];
		p0_x   = joya0_i[7:0];
		p0_y   = joya0_i[15:8];

		if (emu_active_i) begin
			// Mouse buttons take over fire 2 and fire 3
			p0_dig[joy_pkg::fire2_bit +: 2] = btn_i;
			// Low byte of a saturated position is its two's complement byte
			p0_x = pos_x_i[7:0];
			p0_y = pos_y_i[7:0];
		end

		p1_dig = joy1_i[joy_pkg::joy_digital_w-1:0];
		p1_x   = joya1_i[7:0];
		p1_y   = joya1_i[15:8];
	end

	// ====================
	// Port assignment
	// ====================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			joy1_o   <= '0;
			joy2_o   <= '0;
			joy1_x_o <= '0;
			joy1_y_o <= '0;
			joy2_x_o <= '0;
			joy2_y_o <= '0;
		end else if (swap_joy_i) begin
			joy1_o   <= p1_dig;
			joy1_x_o <= p1_x;
			joy1_y_o <= p1_y;
			joy2_o   <= p0_dig;
			joy2_x_o <= p0_x;
			joy2_y_o <= p0_y;
		end else begin
			joy1_o   <= p0_dig;
			joy1_x_o <= p0_x;
			joy1_y_o <= p0_y;
			joy2_o   <= p1_dig;
			joy2_x_o <= p1_x;
			joy2_y_o <= p1_y;
		end
	end

endmodule
